//--- rtl/uart_rx_pkg.sv
`default_nettype none

package uart_rx_pkg;

  // Bit timing for a 10 MHz clock at 1 Mbaud
  localparam int CLOCKS_PER_BIT = 10;

  // Start bit is confirmed in the middle of its period
  localparam int HALF_BIT = CLOCKS_PER_BIT / 2;

  // 8N1 framing
  localparam int DATA_BITS = 8;

  // One received character
  typedef logic [DATA_BITS-1:0] uart_byte_t;

  // Counts clock cycles within a bit, up to CLOCKS_PER_BIT - 1
  typedef logic [$clog2(CLOCKS_PER_BIT)-1:0] baud_cnt_t;

  // Index of the current data bit
  typedef logic [$clog2(DATA_BITS)-1:0] bit_idx_t;

  // Line sampler FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } sampler_state_t;

  // Mid-bit sample passed from the sampler to the assembler
  typedef struct packed {
    logic strobe;   // sample present this cycle
    logic is_stop;  // sample belongs to the stop bit
    logic level;    // sampled line value
  } rx_sample_t;

endpackage

`default_nettype wire

//--- rtl/uart_line_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module uart_line_sampler
  import uart_rx_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx_pin,
  output rx_sample_t sample
);

  // Two-flop synchronizer on the asynchronous pin
  logic rx_meta;
  logic rx_sync;

  sampler_state_t state;
  sampler_state_t state_nxt;
  baud_cnt_t      baud_cnt;
  baud_cnt_t      baud_cnt_nxt;
  bit_idx_t       bit_idx;
  bit_idx_t       bit_idx_nxt;

  logic half_done;
  logic bit_done;
  logic last_bit;

  // Line idles high, so the synchronizer resets high to avoid a false start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_pin;
      rx_sync <= rx_meta;
    end
  end

  assign half_done = (baud_cnt == baud_cnt_t'(HALF_BIT - 1));
  assign bit_done  = (baud_cnt == baud_cnt_t'(CLOCKS_PER_BIT - 1));
  assign last_bit  = (bit_idx == bit_idx_t'(DATA_BITS - 1));

  // Next-state logic
  always_comb begin
    state_nxt    = state;
    baud_cnt_nxt = baud_cnt + 1'b1;
    bit_idx_nxt  = bit_idx;

    case (state)
      ST_IDLE: begin
        // Counter stays at zero until a falling edge shows up
        baud_cnt_nxt = '0;
        if (!rx_sync) begin
          state_nxt = ST_START;
        end
      end

      ST_START: begin
        if (half_done) begin
          baud_cnt_nxt = '0;
          bit_idx_nxt  = '0;
          // Line back high at mid start bit means a glitch
          if (rx_sync) begin
            state_nxt = ST_IDLE;
          end else begin
            state_nxt = ST_DATA;
          end
        end
      end

      ST_DATA: begin
        if (bit_done) begin
          baud_cnt_nxt = '0;
          if (last_bit) begin
            state_nxt = ST_STOP;
          end else begin
            bit_idx_nxt = bit_idx + 1'b1;
          end
        end
      end

      ST_STOP: begin
        // Back to idle right at mid stop bit, ready for the next edge
        if (bit_done) begin
          baud_cnt_nxt = '0;
          state_nxt    = ST_IDLE;
        end
      end

      default: begin
        baud_cnt_nxt = '0;
        state_nxt    = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else begin
      state    <= state_nxt;
      baud_cnt <= baud_cnt_nxt;
      bit_idx  <= bit_idx_nxt;
    end
  end

  // Sample output is combinational so the assembler sees it with no extra delay
  always_comb begin
    sample.strobe  = bit_done && ((state == ST_DATA) || (state == ST_STOP));
    sample.is_stop = (state == ST_STOP);
    sample.level   = rx_sync;
  end

endmodule

`default_nettype wire

//--- rtl/uart_frame_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module uart_frame_assembler
  import uart_rx_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  rx_sample_t sample,
  output logic       byte_strobe,
  output uart_byte_t byte_data,
  output logic       frame_err
);

  uart_byte_t shift_reg;

  logic data_shift;
  logic stop_seen;

  assign data_shift = sample.strobe && !sample.is_stop;
  assign stop_seen  = sample.strobe && sample.is_stop;

  // LSB first on the line, so shift in from the top
  always_ff @(posedge clk) begin
    if (data_shift) begin
      shift_reg <= {sample.level, shift_reg[DATA_BITS-1:1]};
    end
  end

  // Byte is captured at the stop bit and held until the next frame ends
  always_ff @(posedge clk) begin
    if (stop_seen) begin
      byte_data <= shift_reg;
    end
  end

  // One-cycle result pulses, one cycle after the stop sample
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      byte_strobe <= 1'b0;
      frame_err   <= 1'b0;
    end else begin
      byte_strobe <= stop_seen && sample.level;
      // Low stop bit drops the whole frame
      frame_err   <= stop_seen && !sample.level;
    end
  end

endmodule

`default_nettype wire

//--- rtl/uart_rx_holding.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_holding
  import uart_rx_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       byte_strobe,
  input  uart_byte_t byte_data,
  output logic       rx_valid,
  output uart_byte_t rx_data,
  input  logic       rx_ready,
  output logic       overrun
);

  logic transfer;
  logic load;
  logic drop;

  assign transfer = rx_valid && rx_ready;

  // New byte fits if the buffer is empty or drains this cycle
  assign load = byte_strobe && (!rx_valid || rx_ready);

  // Held byte still waiting, so the new one is refused
  assign drop = byte_strobe && rx_valid && !rx_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_valid <= 1'b0;
      overrun  <= 1'b0;
    end else begin
      if (load) begin
        rx_valid <= 1'b1;
      end else if (transfer) begin
        rx_valid <= 1'b0;
      end
      overrun <= drop;
    end
  end

  // Data only changes on a load, which keeps it stable under back-pressure
  always_ff @(posedge clk) begin
    if (load) begin
      rx_data <= byte_data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import uart_rx_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx_pin,
  output logic       rx_valid,
  output uart_byte_t rx_data,
  input  logic       rx_ready,
  output logic       frame_err,
  output logic       overrun
);

  // Sampler to assembler
  rx_sample_t sample;

  // Assembler to holding stage
  logic       byte_strobe;
  uart_byte_t byte_data;

  uart_line_sampler line_sampler_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx_pin (rx_pin),
    .sample (sample)
  );

  uart_frame_assembler frame_assembler_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .sample      (sample),
    .byte_strobe (byte_strobe),
    .byte_data   (byte_data),
    .frame_err   (frame_err)
  );

  uart_rx_holding holding_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .byte_strobe (byte_strobe),
    .byte_data   (byte_data),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .rx_ready    (rx_ready),
    .overrun     (overrun)
  );

endmodule

`default_nettype wire

//--- tests/uart_rx_properties.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_properties
  import uart_rx_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       rx_valid,
  input uart_byte_t rx_data,
  input logic       rx_ready,
  input logic       frame_err,
  input logic       overrun
);

  // Outputs are cleared by a cycle of synchronous reset
  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> (!rx_valid && !frame_err && !overrun))
    else $error("outputs active after a reset cycle");

  // Stalled output keeps both valid and data
  hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_data)))
    else $error("rx_valid or rx_data changed while stalled");

  // A bad frame never puts a byte on the output
  no_bad_delivery: assert property (@(posedge clk) disable iff (!rst_n)
    frame_err |=> !$rose(rx_valid))
    else $error("byte delivered from a frame with a framing error");

endmodule

bind uart_rx uart_rx_properties uart_rx_properties_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .rx_valid  (rx_valid),
  .rx_data   (rx_data),
  .rx_ready  (rx_ready),
  .frame_err (frame_err),
  .overrun   (overrun)
);

`default_nettype wire

//--- tests/uart_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_tb
  import uart_rx_pkg::*;
();

  // Run limit from the frames sent over all tests plus idle gaps
  localparam int FRAMES_SENT     = 39;
  localparam int IDLE_GAP_CYCLES = 500;
  localparam int TIMEOUT_CYCLES  = 2 * FRAMES_SENT * 10 * CLOCKS_PER_BIT + IDLE_GAP_CYCLES;

  logic       clk;
  logic       rst_n;
  logic       rx_pin;
  logic       rx_ready;
  logic       rx_valid;
  uart_byte_t rx_data;
  logic       frame_err;
  logic       overrun;

  // Scoreboard of bytes expected on the output, in order
  uart_byte_t expected[$];
  uart_byte_t stream[$];
  uart_byte_t exp_byte;
  logic [31:0] rand_word;
  integer     seed;
  int errors;
  int monitor_errors;
  int errs_before;
  int xfer_cnt;
  int ferr_cnt;
  int ovr_cnt;
  int cycle_cnt;
  int base_xfer;
  int base_ferr;
  int base_ovr;

  uart_rx uart_rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_pin    (rx_pin),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .rx_ready  (rx_ready),
    .frame_err (frame_err),
    .overrun   (overrun)
  );

  always #5 clk = ~clk;

  // Output monitor counts events and checks each transfer against the scoreboard
  always @(posedge clk) begin
    if (rst_n) begin
      if (rx_valid && rx_ready) begin
        xfer_cnt <= xfer_cnt + 1;
        if (expected.size() == 0) begin
          $display("Transfer of 0x%0h at %0t while no byte was expected", rx_data, $time);
          monitor_errors = monitor_errors + 1;
        end else begin
          exp_byte = expected.pop_front();
          assert (rx_data == exp_byte) else begin
            $display("CHECK FAILED at %0t: rx_data expected 0x%0h, got 0x%0h",
                     $time, exp_byte, rx_data);
            monitor_errors = monitor_errors + 1;
          end
        end
      end
      if (frame_err) begin
        ferr_cnt <= ferr_cnt + 1;
      end
      if (overrun) begin
        ovr_cnt <= ovr_cnt + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input int expected_val, input int actual_val);
    assert (actual_val == expected_val) else begin
      $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
               $time, name, expected_val, actual_val);
      errors = errors + 1;
    end
  endtask

  // Start bit, LSB-first data, then a stop bit that can be forced low
  task automatic send_frame(input uart_byte_t data, input logic bad_stop);
    rx_pin = 1'b0;
    repeat (CLOCKS_PER_BIT) @(negedge clk);
    for (int i = 0; i < DATA_BITS; i++) begin
      rx_pin = data[i];
      repeat (CLOCKS_PER_BIT) @(negedge clk);
    end
    rx_pin = !bad_stop;
    repeat (CLOCKS_PER_BIT) @(negedge clk);
    rx_pin = 1'b1;
  endtask

  task automatic idle_bits(input int count);
    rx_pin = 1'b1;
    repeat (count * CLOCKS_PER_BIT) @(negedge clk);
  endtask

  task automatic wait_transfers(input int target);
    while (xfer_cnt < target) @(negedge clk);
  endtask

  task automatic wait_frame_errors(input int target);
    while (ferr_cnt < target) @(negedge clk);
  endtask

  task automatic wait_overruns(input int target);
    while (ovr_cnt < target) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    if (errors + monitor_errors == errs_at_start) begin
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: FAILED", name);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    rx_pin = 1'b1;
    rx_ready = 1'b0;
    seed = 92;
    errors = 0;
    monitor_errors = 0;
    xfer_cnt = 0;
    ferr_cnt = 0;
    ovr_cnt = 0;
    cycle_cnt = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // Known patterns, walking ones and random bytes with ready held high
    errs_before = errors + monitor_errors;
    base_xfer = xfer_cnt;
    check_value("rx_valid", 0, int'(rx_valid));
    check_value("frame_err", 0, int'(frame_err));
    check_value("overrun", 0, int'(overrun));
    rx_ready = 1'b1;
    stream = '{8'h55, 8'hAA, 8'h00, 8'hFF};
    for (int i = 0; i < DATA_BITS; i++) begin
      stream.push_back(uart_byte_t'(1 << i));
    end
    repeat (20) begin
      rand_word = $random(seed);
      stream.push_back(rand_word[7:0]);
    end
    foreach (stream[k]) begin
      expected.push_back(stream[k]);
      send_frame(stream[k], 1'b0);
      wait_transfers(base_xfer + k + 1);
    end
    idle_bits(2);
    check_value("transfer count", base_xfer + stream.size(), xfer_cnt);
    check_value("scoreboard depth", 0, expected.size());
    check_value("frame_err count", 0, ferr_cnt);
    check_value("overrun count", 0, ovr_cnt);
    report_test("stream", errs_before);

    // Short low glitch must not start a frame
    errs_before = errors + monitor_errors;
    base_xfer = xfer_cnt;
    base_ferr = ferr_cnt;
    rx_pin = 1'b0;
    repeat (CLOCKS_PER_BIT / 4) @(negedge clk);
    idle_bits(2);
    expected.push_back(8'h42);
    send_frame(8'h42, 1'b0);
    wait_transfers(base_xfer + 1);
    idle_bits(1);
    check_value("transfer count", base_xfer + 1, xfer_cnt);
    check_value("frame_err count", base_ferr, ferr_cnt);
    check_value("scoreboard depth", 0, expected.size());
    report_test("false_start", errs_before);

    // Low stop bit drops the frame and the line needs a gap to resync
    errs_before = errors + monitor_errors;
    base_xfer = xfer_cnt;
    base_ferr = ferr_cnt;
    send_frame(8'hFF, 1'b1);
    wait_frame_errors(base_ferr + 1);
    idle_bits(2);
    check_value("frame_err count", base_ferr + 1, ferr_cnt);
    check_value("transfer count", base_xfer, xfer_cnt);
    expected.push_back(8'h42);
    send_frame(8'h42, 1'b0);
    wait_transfers(base_xfer + 1);
    idle_bits(1);
    check_value("transfer count", base_xfer + 1, xfer_cnt);
    check_value("frame_err count", base_ferr + 1, ferr_cnt);
    report_test("framing_error", errs_before);

    // Held byte stays put while ready is low
    errs_before = errors + monitor_errors;
    base_xfer = xfer_cnt;
    rx_ready = 1'b0;
    expected.push_back(8'h5A);
    send_frame(8'h5A, 1'b0);
    while (!rx_valid) @(negedge clk);
    repeat (100) begin
      @(negedge clk);
      check_value("rx_valid", 1, int'(rx_valid));
      check_value("rx_data", 'h5A, int'(rx_data));
    end
    check_value("transfer count", base_xfer, xfer_cnt);
    rx_ready = 1'b1;
    wait_transfers(base_xfer + 1);
    check_value("rx_valid", 0, int'(rx_valid));
    expected.push_back(8'h3C);
    send_frame(8'h3C, 1'b0);
    wait_transfers(base_xfer + 2);
    idle_bits(2);
    check_value("transfer count", base_xfer + 2, xfer_cnt);
    check_value("scoreboard depth", 0, expected.size());
    report_test("back_pressure", errs_before);

    // Second byte arrives while the first is still held
    errs_before = errors + monitor_errors;
    base_xfer = xfer_cnt;
    base_ovr = ovr_cnt;
    rx_ready = 1'b0;
    expected.push_back(8'h11);
    send_frame(8'h11, 1'b0);
    send_frame(8'h22, 1'b0);
    wait_overruns(base_ovr + 1);
    idle_bits(1);
    check_value("overrun count", base_ovr + 1, ovr_cnt);
    check_value("transfer count", base_xfer, xfer_cnt);
    check_value("rx_data", 'h11, int'(rx_data));
    rx_ready = 1'b1;
    wait_transfers(base_xfer + 1);
    idle_bits(3);
    check_value("transfer count", base_xfer + 1, xfer_cnt);
    check_value("scoreboard depth", 0, expected.size());
    check_value("rx_valid", 0, int'(rx_valid));
    report_test("overrun", errs_before);

    $display("Transfers %0d, frame errors %0d, overruns %0d, errors %0d",
             xfer_cnt, ferr_cnt, ovr_cnt, errors + monitor_errors);
    if (errors + monitor_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
rtl/uart_rx_pkg.sv
rtl/uart_line_sampler.sv
rtl/uart_frame_assembler.sv
rtl/uart_rx_holding.sv
rtl/uart_rx.sv
tests/uart_rx_properties.sv
tests/uart_rx_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the UART receiver testbench with Verilator
set -e

verilator --binary -j 0 --assert --timescale 1ns/1ps \
  --top-module uart_rx_tb -f tb.f -o uart_rx_sim

./obj_dir/uart_rx_sim | tee sim.log

if grep -qx "Simulation passed" sim.log; then
  exit 0
else
  exit 1
fi
